// ==== src/mvau_defines.svh ====
`ifndef MVAU_DEFINES_SVH
`define MVAU_DEFINES_SVH

// Elements per input slice
`define MVAU_SIMD 2
// Output lanes, one accumulator each
`define MVAU_PE 2
// Slices per input vector
`define MVAU_SF 4
// Filter passes over the same vector
`define MVAU_NF 3

// Signed activation, weight and accumulator widths
`define MVAU_TA 4
`define MVAU_TW 4
`define MVAU_TACC 16

// Weight memory holds SF x NF tiles
`define MVAU_WMEM_DEPTH 12
`define MVAU_WMEM_AW 4

// Counter widths for sf and nf
`define MVAU_SF_W 2
`define MVAU_NF_W 2

`endif

// ==== src/mvau_pkg.sv ====
`include "mvau_defines.svh"

package mvau_pkg;

   // Single signed activation element
   typedef logic signed [`MVAU_TA-1:0] act_t;
   // Single signed weight element
   typedef logic signed [`MVAU_TW-1:0] wgt_t;
   // Single signed accumulator
   typedef logic signed [`MVAU_TACC-1:0] acc_t;

   // One input slice of SIMD activations
   typedef act_t [`MVAU_SIMD-1:0] act_vec_t;

   // One weight tile, PE rows of SIMD weights, one memory word
   typedef wgt_t [`MVAU_PE-1:0][`MVAU_SIMD-1:0] wgt_tile_t;

   // One output group of PE accumulators
   typedef acc_t [`MVAU_PE-1:0] acc_vec_t;

   // Per-cycle control flags from the control block
   typedef struct packed {
      logic do_mvau;
      logic sf_first;
      logic sf_last;
      logic replay;
   } mvau_ctrl_t;

   // Request on the single weight memory port
   typedef struct packed {
      logic                     we;
      logic [`MVAU_WMEM_AW-1:0] addr;
      wgt_tile_t                wdata;
   } wmem_req_t;

   // External weight load write
   typedef struct packed {
      logic [`MVAU_WMEM_AW-1:0] addr;
      wgt_tile_t                data;
   } wload_t;

endpackage

// ==== src/mvau_control_block.sv ====
`timescale 1ns/1ps
`include "mvau_defines.svh"

module mvau_control_block
   import mvau_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     in_v,
   output mvau_ctrl_t               ctrl,
   output logic [`MVAU_WMEM_AW-1:0] wmem_addr,
   output logic                     busy
);

   localparam int SF    = `MVAU_SF;
   localparam int NF    = `MVAU_NF;
   localparam int SF_W  = `MVAU_SF_W;
   localparam int NF_W  = `MVAU_NF_W;
   localparam int AW    = `MVAU_WMEM_AW;
   localparam int DEPTH = `MVAU_WMEM_DEPTH;

   logic [SF_W-1:0] sf_cnt;
   logic [NF_W-1:0] nf_cnt;
   logic            replay;
   logic            do_mvau;
   logic            sf_wrap;
   logic            nf_wrap;

   // Passes after the first run from the stored slices
   assign replay  = (nf_cnt != '0);
   // Compute on fresh input or while replaying
   assign do_mvau = in_v | replay;
   assign sf_wrap = (sf_cnt == SF_W'(SF - 1));
   assign nf_wrap = (nf_cnt == NF_W'(NF - 1));

   assign busy = replay;

   // Flags describe the slice handled in this cycle
   assign ctrl.do_mvau  = do_mvau;
   assign ctrl.sf_first = (sf_cnt == '0);
   assign ctrl.sf_last  = sf_wrap;
   assign ctrl.replay   = replay;

   // Slice counter, one step per compute cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sf_cnt <= '0;
      end else if (do_mvau) begin
         sf_cnt <= sf_wrap ? '0 : sf_cnt + 1'b1;
      end
   end

   // Filter pass counter bumps when a slice sweep ends
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         nf_cnt <= '0;
      end else if (do_mvau && sf_wrap) begin
         nf_cnt <= nf_wrap ? '0 : nf_cnt + 1'b1;
      end
   end

   // Weight tile address walks nf*SF+sf in order
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wmem_addr <= '0;
      end else if (do_mvau) begin
         wmem_addr <= (wmem_addr == AW'(DEPTH - 1)) ? '0 : wmem_addr + 1'b1;
      end
   end

endmodule

// ==== src/mvau_input_buffer.sv ====
`timescale 1ns/1ps
`include "mvau_defines.svh"

module mvau_input_buffer
   import mvau_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  mvau_ctrl_t ctrl,
   input  act_vec_t   in_data,
   output act_vec_t   act
);

   localparam int SF   = `MVAU_SF;
   localparam int SF_W = `MVAU_SF_W;

   // One entry per slice of the current vector
   act_vec_t        slices [SF];
   logic [SF_W-1:0] idx;

   // Own slice index, realigned by the last-slice flag
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         idx <= '0;
      end else if (ctrl.do_mvau) begin
         idx <= ctrl.sf_last ? '0 : idx + 1'b1;
      end
   end

   // First pass stores fresh input
   always_ff @(posedge clk) begin
      if (ctrl.do_mvau && !ctrl.replay) begin
         slices[idx] <= in_data;
      end
   end

   // Registered output lines up with the memory read latency
   // Fresh slice forwarded on the first pass, stored one on replay
   always_ff @(posedge clk) begin
      if (ctrl.do_mvau) begin
         act <= ctrl.replay ? slices[idx] : in_data;
      end
   end

endmodule

// ==== src/mvau_wmem_arbiter.sv ====
`timescale 1ns/1ps
`include "mvau_defines.svh"

module mvau_wmem_arbiter
   import mvau_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  mvau_ctrl_t               ctrl,
   input  logic [`MVAU_WMEM_AW-1:0] rd_addr,
   input  logic                     wload_v,
   input  wload_t                   wload,
   output wmem_req_t                req,
   output logic                     wload_pend
);

   // One-entry slot for a write that lost to compute
   logic   pend_v;
   wload_t pend;
   logic   park;

   // Collision with compute and the slot is free
   assign park = ctrl.do_mvau & wload_v & ~pend_v;

   assign wload_pend = pend_v;

   // Port grant, compute first, then parked, then fresh write
   always_comb begin
      req       = '0;
      req.addr  = rd_addr;
      if (!ctrl.do_mvau) begin
         if (pend_v) begin
            req.we    = 1'b1;
            req.addr  = pend.addr;
            req.wdata = pend.data;
         end else if (wload_v) begin
            req.we    = 1'b1;
            req.addr  = wload.addr;
            req.wdata = wload.data;
         end
      end
   end

   // Slot fills on collision, empties on the first free cycle
   // A write arriving while the slot is full is lost
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pend_v <= 1'b0;
      end else if (park) begin
         pend_v <= 1'b1;
      end else if (!ctrl.do_mvau) begin
         pend_v <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (park) begin
         pend <= wload;
      end
   end

endmodule

// ==== src/mvau_weight_mem.sv ====
`timescale 1ns/1ps
`include "mvau_defines.svh"

module mvau_weight_mem
   import mvau_pkg::*;
(
   input  logic      clk,
   input  wmem_req_t req,
   output wgt_tile_t rdata
);

   localparam int DEPTH = `MVAU_WMEM_DEPTH;

   // One tile per word
   wgt_tile_t mem [DEPTH];

   // Writes past the last tile are ignored
   always_ff @(posedge clk) begin
      if (req.we && (int'(req.addr) < DEPTH)) begin
         mem[req.addr] <= req.wdata;
      end
   end

   // Read data one cycle after the request
   always_ff @(posedge clk) begin
      rdata <= mem[req.addr];
   end

endmodule

// ==== src/mvau_pe_array.sv ====
`timescale 1ns/1ps
`include "mvau_defines.svh"

module mvau_pe_array
   import mvau_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  mvau_ctrl_t ctrl,
   input  act_vec_t   act,
   input  wgt_tile_t  wgt,
   output logic       out_v,
   output acc_vec_t   out_data
);

   localparam int PE   = `MVAU_PE;
   localparam int SIMD = `MVAU_SIMD;
   localparam int PW   = `MVAU_TA + `MVAU_TW;

   // Flags delayed to meet the slice and tile arriving a cycle late
   mvau_ctrl_t ctrl_q;
   acc_vec_t   acc;
   acc_vec_t   acc_nxt;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ctrl_q <= '0;
      end else begin
         ctrl_q <= ctrl;
      end
   end

   // Per lane dot product over SIMD, added to the running sum
   always_comb begin : lane_sum
      logic signed [PW-1:0] prod;
      for (int p = 0; p < PE; p++) begin
         acc_nxt[p] = ctrl_q.sf_first ? '0 : acc[p];
         for (int s = 0; s < SIMD; s++) begin
            prod       = $signed(act[s]) * $signed(wgt[p][s]);
            acc_nxt[p] = acc_nxt[p] + prod;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl_q.do_mvau) begin
         acc <= acc_nxt;
      end
      // Group finished on the last slice of a pass
      if (ctrl_q.do_mvau && ctrl_q.sf_last) begin
         out_data <= acc_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_v <= 1'b0;
      end else begin
         out_v <= ctrl_q.do_mvau & ctrl_q.sf_last;
      end
   end

endmodule

// ==== src/mvau_top.sv ====
`timescale 1ns/1ps
`include "mvau_defines.svh"

module mvau_top
   import mvau_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_v,
   input  act_vec_t in_data,
   input  logic     wload_v,
   input  wload_t   wload,
   output logic     out_v,
   output acc_vec_t out_data,
   output logic     busy,
   output logic     wload_pend
);

   mvau_ctrl_t               ctrl;
   logic [`MVAU_WMEM_AW-1:0] wmem_addr;
   wmem_req_t                req;
   wgt_tile_t                rdata;
   act_vec_t                 act;

   // Counters, flags and read address
   mvau_control_block u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_v      (in_v),
      .ctrl      (ctrl),
      .wmem_addr (wmem_addr),
      .busy      (busy)
   );

   // Slice capture and replay
   mvau_input_buffer u_ibuf (
      .clk     (clk),
      .rst_n   (rst_n),
      .ctrl    (ctrl),
      .in_data (in_data),
      .act     (act)
   );

   // Compute reads and load writes share one port
   mvau_wmem_arbiter u_arb (
      .clk        (clk),
      .rst_n      (rst_n),
      .ctrl       (ctrl),
      .rd_addr    (wmem_addr),
      .wload_v    (wload_v),
      .wload      (wload),
      .req        (req),
      .wload_pend (wload_pend)
   );

   mvau_weight_mem u_wmem (
      .clk   (clk),
      .req   (req),
      .rdata (rdata)
   );

   mvau_pe_array u_pe (
      .clk      (clk),
      .rst_n    (rst_n),
      .ctrl     (ctrl),
      .act      (act),
      .wgt      (rdata),
      .out_v    (out_v),
      .out_data (out_data)
   );

endmodule

// ==== test/mvau_assert.sv ====
`timescale 1ns/1ps
`include "mvau_defines.svh"

module mvau_assert (
   input logic                     clk,
   input logic                     rst_n,
   input logic                     in_v,
   input logic                     busy,
   input logic                     do_mvau,
   input logic                     we,
   input logic [`MVAU_WMEM_AW-1:0] addr
);

   // New vector only once replay has ended
   a_no_input_while_busy : assert property (
      @(posedge clk) disable iff (!rst_n) !(in_v && busy)
   ) else $error("in_v high while busy");

   // Compute read owns the memory port
   a_no_write_on_compute : assert property (
      @(posedge clk) disable iff (!rst_n) !(we && do_mvau)
   ) else $error("weight write granted during a compute cycle");

   a_addr_in_range : assert property (
      @(posedge clk) disable iff (!rst_n) int'(addr) < `MVAU_WMEM_DEPTH
   ) else $error("weight address past the last tile");

endmodule

bind mvau_control_block mvau_assert u_ctrl_assert (
   .clk     (clk),
   .rst_n   (rst_n),
   .in_v    (in_v),
   .busy    (busy),
   .do_mvau (ctrl.do_mvau),
   .we      (1'b0),
   .addr    (wmem_addr)
);

bind mvau_wmem_arbiter mvau_assert u_arb_assert (
   .clk     (clk),
   .rst_n   (rst_n),
   .in_v    (1'b0),
   .busy    (1'b0),
   .do_mvau (ctrl.do_mvau),
   .we      (req.we),
   .addr    (req.addr)
);

// ==== test/mvau_tb.sv ====
`timescale 1ns/1ps
`include "mvau_defines.svh"

module mvau_tb
   import mvau_pkg::*;
();

   localparam int SIMD   = `MVAU_SIMD;
   localparam int PE     = `MVAU_PE;
   localparam int SF     = `MVAU_SF;
   localparam int NF     = `MVAU_NF;
   localparam int DEPTH  = `MVAU_WMEM_DEPTH;
   localparam int ACT_W  = SIMD * `MVAU_TA;
   localparam int TILE_W = PE * SIMD * `MVAU_TW;
   localparam int CLK_NS = 100;
   // Most negative activation and weight
   localparam act_t AMIN = {1'b1, {(`MVAU_TA - 1){1'b0}}};
   localparam wgt_t WMIN = {1'b1, {(`MVAU_TW - 1){1'b0}}};
   // Worst vector has a two-cycle gap before every slice
   localparam int VEC_CYC  = SF * 3 + SF * NF + 8;
   localparam int LOAD_CYC = DEPTH * 2 + 2;
   // Reset, idle check, two full loads, nine vectors, drains, then doubled
   localparam int RUN_CYC  = 2 * (10 + 30 + 2 * LOAD_CYC + 9 * VEC_CYC + 7 * 8);

   logic     clk;
   logic     rst_n;
   logic     in_v;
   act_vec_t in_data;
   logic     wload_v;
   wload_t   wload;
   logic     out_v;
   acc_vec_t out_data;
   logic     busy;
   logic     wload_pend;

   // Reference copy of weight memory and of the vector in flight
   wgt_tile_t wmodel [DEPTH];
   act_vec_t  cur_vec [SF];
   // Expected groups with their arrival cycles
   acc_vec_t  exp_q [$];
   int        cyc_q [$];
   int        cyc = 0;
   int        n_checks;
   int        n_errors;

   mvau_top dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_v       (in_v),
      .in_data    (in_data),
      .wload_v    (wload_v),
      .wload      (wload),
      .out_v      (out_v),
      .out_data   (out_data),
      .busy       (busy),
      .wload_pend (wload_pend)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // Cycle index, stable when read at the falling edge
   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   task automatic compare_value(input string what, input int got, input int exp);
      n_checks++;
      assert (got == exp) else begin
         n_errors++;
         $display("error t=%0t %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   // Lane p of pass n sums tile n*SF+sf, row p, times slice sf over all elements
   function automatic acc_vec_t model_group(input int n);
      acc_vec_t g;
      int       sum;
      for (int p = 0; p < PE; p++) begin
         sum = 0;
         for (int f = 0; f < SF; f++) begin
            for (int s = 0; s < SIMD; s++) begin
               sum += int'($signed(wmodel[n * SF + f][p][s])) * int'($signed(cur_vec[f][s]));
            end
         end
         g[p] = `MVAU_TACC'(sum);
      end
      return g;
   endfunction

   // Output groups checked against the queue, value and arrival cycle
   always @(negedge clk) begin
      acc_vec_t g;
      int       t;
      if (rst_n && out_v) begin
         n_checks++;
         assert (exp_q.size() != 0) else begin
            n_errors++;
            $display("unexpected output group at %0t with no vector in flight", $time);
         end
         if (exp_q.size() != 0) begin
            g = exp_q.pop_front();
            t = cyc_q.pop_front();
            compare_value("output cycle", cyc, t);
            for (int p = 0; p < PE; p++) begin
               compare_value($sformatf("lane %0d", p), int'($signed(out_data[p])),
                             int'($signed(g[p])));
            end
         end
      end
   end

   task automatic load_tile(input int addr, input wgt_tile_t tile);
      @(posedge clk);
      wload_v    <= 1'b1;
      wload.addr <= `MVAU_WMEM_AW'(addr);
      wload.data <= tile;
      @(posedge clk);
      wload_v    <= 1'b0;
   endtask

   task automatic load_all(input bit minimum);
      wgt_tile_t tile;
      for (int a = 0; a < DEPTH; a++) begin
         tile = minimum ? {(PE * SIMD){WMIN}} : TILE_W'($urandom);
         wmodel[a] = tile;
         load_tile(a, tile);
      end
   endtask

   task automatic new_vector(input bit minimum);
      foreach (cur_vec[i]) begin
         cur_vec[i] = minimum ? {SIMD{AMIN}} : ACT_W'($urandom);
      end
   endtask

   task automatic wait_idle();
      @(negedge clk);
      while (busy) begin
         @(negedge clk);
      end
   endtask

   // First pass from input, one to max_gap idle cycles before each later slice
   task automatic stream_vector(input int max_gap);
      int t_last;
      int gap;
      wait_idle();
      for (int i = 0; i < SF; i++) begin
         gap = (i > 0 && max_gap > 0) ? $urandom_range(max_gap, 1) : 0;
         repeat (gap) begin
            @(posedge clk);
            in_v <= 1'b0;
         end
         @(posedge clk);
         in_v    <= 1'b1;
         in_data <= cur_vec[i];
      end
      @(negedge clk);
      t_last = cyc;
      // Pass n closes SF cycles after pass n-1
      for (int n = 0; n < NF; n++) begin
         exp_q.push_back(model_group(n));
         cyc_q.push_back(t_last + 2 + n * SF);
      end
      @(posedge clk);
      in_v <= 1'b0;
   endtask

   task automatic drain();
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      repeat (4) @(negedge clk);
   endtask

   task automatic test_reset_idle();
      @(negedge clk);
      compare_value("out_v after reset", int'(out_v), 0);
      compare_value("busy after reset", int'(busy), 0);
      compare_value("wload_pend after reset", int'(wload_pend), 0);
      // Monitor flags any stray group
      repeat (20) @(negedge clk);
   endtask

   task automatic test_single_vector();
      load_all(1'b0);
      new_vector(1'b0);
      stream_vector(0);
      drain();
   endtask

   task automatic test_gapped_vector();
      new_vector(1'b0);
      stream_vector(2);
      drain();
   endtask

   // Back to back vectors walk the counters and address through several wraps
   task automatic test_vector_train();
      for (int v = 0; v < 4; v++) begin
         new_vector(1'b0);
         stream_vector(v % 2);
      end
      drain();
   endtask

   task automatic test_parked_write();
      wgt_tile_t tile;
      new_vector(1'b0);
      stream_vector(0);
      tile = ~wmodel[0];
      // Replay owns the port here
      load_tile(0, tile);
      @(negedge clk);
      compare_value("busy during replay", int'(busy), 1);
      compare_value("wload_pend while busy", int'(wload_pend), 1);
      wait_idle();
      @(negedge clk);
      compare_value("wload_pend after passes", int'(wload_pend), 0);
      wmodel[0] = tile;
      drain();
      new_vector(1'b0);
      stream_vector(0);
      drain();
   endtask

   task automatic test_extreme_values();
      load_all(1'b1);
      new_vector(1'b1);
      stream_vector(0);
      drain();
   endtask

   initial begin
      rst_n    = 1'b0;
      in_v     = 1'b0;
      in_data  = '0;
      wload_v  = 1'b0;
      wload    = '0;
      n_checks = 0;
      n_errors = 0;
      void'($urandom(32'hd5d3));
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      test_reset_idle();
      test_single_vector();
      test_gapped_vector();
      test_vector_train();
      test_parked_write();
      test_extreme_values();
      $display("checks %0d errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      #(RUN_CYC * CLK_NS);
      $display("watchdog expired, tests did not finish within %0d cycles", RUN_CYC);
      $display("sim failed");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+src
src/mvau_pkg.sv
src/mvau_control_block.sv
src/mvau_input_buffer.sv
src/mvau_wmem_arbiter.sv
src/mvau_weight_mem.sv
src/mvau_pe_array.sv
src/mvau_top.sv
test/mvau_assert.sv
test/mvau_tb.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Wno-fatal -j 0 --top-module mvau_tb -f files.f

run: build
	./obj_dir/Vmvau_tb > sim.log 2>&1; cat sim.log
	grep -qx "sim passed" sim.log

lint:
	verilator --lint-only -Wall --top-module mvau_tb -f files.f
	verilator --lint-only -Wall --top-module mvau_top -f files.f

clean:
	rm -rf obj_dir sim.log
